// ==== Bender.yml ====
package:
  name: cpu_system

sources:
  - hdl/cpu_pkg.sv
  - hdl/decoder.sv
  - hdl/execute.sv
  - hdl/memory_access.sv
  - hdl/write_back.sv
  - hdl/cpu.sv
  - hdl/data_memory.sv
  - hdl/cpu_system.sv
  - target: test
    files:
      - bench/cpu_checker.sv
      - bench/cpu_tb.sv

// ==== bench/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input logic              clock,
  input logic              reset,
  input logic [31:0]       pc,
  input logic [31:0]       instruction,
  input cpu_pkg::mem_req_t dmem_req,
  input logic              debug_ebreak,
  input logic              illegal_instruction,
  input logic [31:0][31:0] debug_regs
);
  import cpu_pkg::*;

  int unsigned error_count = 0;

  opcode_t     opcode;
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic        is_control;
  logic [31:0] control_target;
  logic [31:0] pc_expected;
  logic [31:0] store_address;
  logic [3:0]  store_strobe;

  function automatic logic branch_rule(input logic [2:0] funct3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (funct3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // byte lanes by access size and address offset
  function automatic logic [3:0] store_lanes(input logic [1:0] size, input logic [1:0] offset);
    case (size)
      2'd0:    return 4'b0001 << offset;
      2'd1:    return offset[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  assign opcode = opcode_t'(instruction[6:0]);
  assign rs1_value = debug_regs[instruction[19:15]];
  assign rs2_value = debug_regs[instruction[24:20]];
  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                  instruction[11:8], 1'b0};
  assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                  instruction[30:21], 1'b0};
  assign is_control = !illegal_instruction &&
                      (opcode inside {OPC_BRANCH, OPC_JAL, OPC_JALR});
  assign store_address = rs1_value + imm_s;
  assign store_strobe = store_lanes(instruction[13:12], store_address[1:0]);

  always_comb begin
    case (opcode)
      OPC_JAL:  control_target = pc + imm_j;
      OPC_JALR: control_target = (rs1_value + imm_i) & ~32'd1;
      default: begin
        control_target = branch_rule(instruction[14:12], rs1_value, rs2_value) ?
                         pc + imm_b : pc + 32'd4;
      end
    endcase
  end

  // pc that the previous instruction should lead to
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc_expected <= RESET_PC;
    end else begin
      pc_expected <= is_control ? control_target : pc + 32'd4;
    end
  end

  x0_zero: assert property (@(posedge clock) disable iff (reset) debug_regs[0] == 32'd0)
  else begin
    $error("Mismatch debug_regs[0]: got %h expected %h", $sampled(debug_regs[0]), 32'd0);
    error_count++;
  end

  pc_sequential: assert property (@(posedge clock) disable iff (reset)
    !is_control |=> pc == pc_expected)
  else begin
    $error("Mismatch pc: got %h expected %h after a non-control instruction",
           $sampled(pc), $sampled(pc_expected));
    error_count++;
  end

  pc_control: assert property (@(posedge clock) disable iff (reset)
    is_control |=> pc == pc_expected)
  else begin
    $error("Mismatch pc: got %h expected %h after a branch or jump",
           $sampled(pc), $sampled(pc_expected));
    error_count++;
  end

  // undefined major opcodes
  unknown_opcode: assert property (@(posedge clock) disable iff (reset)
    !(opcode inside {OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_OP_IMM,
                     OPC_OP, OPC_LUI, OPC_AUIPC, OPC_SYSTEM}) |-> illegal_instruction)
  else begin
    $error("undefined opcode was not flagged as illegal");
    error_count++;
  end

  illegal_no_write: assert property (@(posedge clock) disable iff (reset)
    illegal_instruction |=> debug_regs == $past(debug_regs))
  else begin
    $error("illegal instruction changed the register file");
    error_count++;
  end

  store_request: assert property (@(posedge clock) disable iff (reset)
    opcode == OPC_STORE && !illegal_instruction |->
      dmem_req.write && !dmem_req.read && dmem_req.address == store_address &&
      dmem_req.strobe == store_strobe)
  else begin
    $error("Mismatch dmem_req: address %h strobe %h write %h read %h, expected %h %h 1 0",
           $sampled(dmem_req.address), $sampled(dmem_req.strobe),
           $sampled(dmem_req.write), $sampled(dmem_req.read),
           $sampled(store_address), $sampled(store_strobe));
    error_count++;
  end

  quiet_in_reset: assert property (@(posedge clock)
    reset |-> !dmem_req.read && !dmem_req.write)
  else begin
    $error("memory request active during reset");
    error_count++;
  end

  ebreak_flag: assert property (@(posedge clock)
    debug_ebreak == (instruction == EBREAK_WORD))
  else begin
    $error("Mismatch debug_ebreak: got %h expected %h", $sampled(debug_ebreak),
           $sampled(instruction) == EBREAK_WORD);
    error_count++;
  end

endmodule

bind cpu_system cpu_checker checker_inst (
  .clock,
  .reset,
  .pc,
  .instruction,
  .dmem_req,
  .debug_ebreak,
  .illegal_instruction,
  .debug_regs
);

`default_nettype wire

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam int CLOCK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int PROG_LEN = 44;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN * 4;
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;
  // sw x13, 0(x19) held on the bus during reset
  localparam logic [31:0] RESET_STORE_WORD = 32'h00D9_A023;
  // lw x20, 0(x19)
  localparam logic [31:0] RESET_LOAD_WORD = 32'h0009_AA03;

  // alu section from 0x00 ending in a write to x0
  // six branches from 0x3c followed by jal x17 at 0x68 and jalr x18 at 0x70
  // words that get skipped would write x15 or x16
  // stores and loads from 0x80 around base x19 = 0x100
  // one undefined opcode ahead of the final ebreak
  localparam logic [31:0] PROGRAM [PROG_LEN] = '{
    32'h0050_0093, 32'hFFD0_0113, 32'h0020_81B3, 32'h4020_8233,
    32'h0030_9293, 32'h4011_5313, 32'h0011_53B3, 32'h0011_2433,
    32'h0011_34B3, 32'h00F0_C513, 32'h0020_E5B3, 32'h0011_7633,
    32'h1234_56B7, 32'h0000_1717, 32'h0070_8013, 32'h00C0_8463,
    32'h0090_0793, 32'h00C0_9463, 32'h0010_0793, 32'h0011_4463,
    32'h0020_0793, 32'h0011_6463, 32'h0030_0813, 32'h0020_D463,
    32'h0040_0813, 32'h0020_F463, 32'h0080_08EF, 32'h0050_0813,
    32'h0158_8967, 32'h0060_0813, 32'h0060_0813, 32'h0060_0813,
    32'h1000_0993, 32'h00D9_A023, 32'h0029_80A3, 32'h0029_9323,
    32'h0009_AA03, 32'h0019_8A83, 32'h0019_CB03, 32'h0069_9B83,
    32'h0069_DC03, 32'h0029_8C83, 32'hFFFF_FFFF, 32'h0010_0073
  };

  logic              clock;
  logic              reset;
  logic [31:0]       pc;
  logic [31:0]       instruction;
  logic              debug_ebreak;
  logic              illegal_instruction;
  logic [31:0][31:0] debug_regs;
  logic [31:0]       expected_regs [32];

  cpu_system DUT (
    .clock,
    .reset,
    .pc,
    .instruction,
    .debug_ebreak,
    .illegal_instruction,
    .debug_regs
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  // addresses past the program read as nop
  function automatic logic [31:0] rom_word(input logic [31:0] address);
    if (address[31:2] < PROG_LEN) begin
      return PROGRAM[address[31:2]];
    end
    return NOP_WORD;
  endfunction

  task automatic build_expected();
    logic [31:0] word0;
    logic [31:0] word1;
    for (int i = 0; i < 32; i++) begin
      expected_regs[i] = '0;
    end
    expected_regs[1] = 32'd5;
    expected_regs[2] = -32'sd3;
    expected_regs[3] = expected_regs[1] + expected_regs[2];
    expected_regs[4] = expected_regs[1] - expected_regs[2];
    expected_regs[5] = expected_regs[1] << 3;
    expected_regs[6] = $signed(expected_regs[2]) >>> 1;
    expected_regs[7] = expected_regs[2] >> expected_regs[1][4:0];
    expected_regs[8] = {31'b0, $signed(expected_regs[2]) < $signed(expected_regs[1])};
    expected_regs[9] = {31'b0, expected_regs[2] < expected_regs[1]};
    expected_regs[10] = expected_regs[1] ^ 32'h0000_000F;
    expected_regs[11] = expected_regs[1] | expected_regs[2];
    expected_regs[12] = expected_regs[2] & expected_regs[1];
    expected_regs[13] = 32'h1234_5000;
    // auipc sits at 0x34
    expected_regs[14] = 32'h0000_0034 + 32'h0000_1000;
    expected_regs[15] = 32'd1;
    expected_regs[16] = 32'd3;
    // link values of jal at 0x68 and jalr at 0x70
    expected_regs[17] = 32'h0000_0068 + 32'd4;
    expected_regs[18] = 32'h0000_0070 + 32'd4;
    expected_regs[19] = 32'h0000_0100;
    // words at 0x100 and 0x104 after sw, sb and sh
    word0 = expected_regs[13];
    word0[15:8] = expected_regs[2][7:0];
    word1 = '0;
    word1[31:16] = expected_regs[2][15:0];
    expected_regs[20] = word0;
    expected_regs[21] = {{24{word0[15]}}, word0[15:8]};
    expected_regs[22] = {24'b0, word0[15:8]};
    expected_regs[23] = {{16{word1[31]}}, word1[31:16]};
    expected_regs[24] = {16'b0, word1[31:16]};
    expected_regs[25] = {{24{word0[23]}}, word0[23:16]};
  endtask

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // final register file checked on the ebreak cycle
  for (genvar n = 0; n < 32; n++) begin : reg_checks
    assert property (@(posedge clock) disable iff (reset)
      $rose(debug_ebreak) |-> debug_regs[n] == expected_regs[n])
    else begin
      abort_run($sformatf("Mismatch debug_regs[%0d]: got %h expected %h",
                          n, $sampled(debug_regs[n]), expected_regs[n]));
    end
  end

  assert property (@(posedge clock) $fell(reset) |-> pc == RESET_PC && debug_regs == '0)
  else begin
    abort_run("pc or register file not cleared by reset");
  end

  initial begin
    wait (DUT.checker_inst.error_count != 0);
    abort_run("an assertion in the bound checker failed");
  end

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    abort_run("timeout, EBREAK was never reached");
  end

  // stores and loads on the bus during reset, then the rom follows pc
  initial begin
    clock = 1'b0;
    reset = 1'b1;
    build_expected();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      instruction = i[0] ? RESET_LOAD_WORD : RESET_STORE_WORD;
      @(posedge clock);
      #1;
    end
    reset = 1'b0;
    forever begin
      instruction = rom_word(pc);
      @(posedge clock);
      #1;
    end
  end

  initial begin
    wait (debug_ebreak === 1'b1);
    repeat (2) @(posedge clock);
    #1;
    if (DUT.checker_inst.error_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run("the bound checker recorded assertion failures");
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic              clock,
  input  logic              reset,
  output logic [31:0]       pc,
  input  logic [31:0]       instruction,
  output cpu_pkg::mem_req_t dmem_req,
  input  logic [31:0]       read_data,
  output logic              debug_ebreak,
  output logic              illegal_instruction,
  output logic [31:0][31:0] debug_regs
);
  import cpu_pkg::*;

  logic [31:0][31:0] regs;
  logic [31:0]       rs1_data;
  logic [31:0]       rs2_data;

  instr_field_t field;
  alu_cmd_t     alu_cmd;
  access_t      access;
  wb_sel_t      wb_sel;
  logic [31:0]  op1;
  logic [31:0]  op2;
  logic [31:0]  alu_out;
  logic         branch_taken;
  logic [3:0]   strobe;
  logic [31:0]  wdata;
  logic         mem_read;
  logic         mem_write;
  logic [31:0]  load_value;
  logic [31:0]  reg_next;
  logic         wb_en;
  logic [31:0]  pc_next;

  // register indices straight from the instruction word
  assign rs1_data = regs[instruction[19:15]];
  assign rs2_data = regs[instruction[24:20]];

  decoder decoder (
    .instruction,
    .pc,
    .rs1_data,
    .rs2_data,
    .field,
    .alu_cmd,
    .access,
    .wb_sel,
    .op1,
    .op2,
    .illegal_instruction
  );

  execute execute (
    .op1,
    .op2,
    .rs1_data,
    .rs2_data,
    .alu_cmd,
    .alu_out,
    .branch_taken
  );

  memory_access memory_access (
    .access,
    .address(alu_out),
    .store_value(rs2_data),
    .read_data,
    .strobe,
    .wdata,
    .read(mem_read),
    .write(mem_write),
    .load_value
  );

  write_back write_back (
    .pc,
    .field,
    .wb_sel,
    .alu_out,
    .branch_taken,
    .load_value,
    .reg_next,
    .wb_en,
    .pc_next
  );

  // no memory traffic while reset is held
  always_comb begin
    dmem_req.address = alu_out;
    dmem_req.wdata = wdata;
    dmem_req.strobe = strobe;
    dmem_req.read = mem_read && !reset;
    dmem_req.write = mem_write && !reset;
  end

  assign debug_ebreak = instruction == EBREAK_WORD;
  assign debug_regs = regs;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc <= RESET_PC;
      regs <= '0;
    end else begin
      pc <= pc_next;
      if (wb_en) begin
        regs[field.rd] <= reg_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_ADDR_BITS = $clog2(DMEM_WORDS);
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  // branch compares also make the adder produce the target
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_cmd_t;

  typedef enum logic [3:0] {
    ACC_NONE,
    ACC_LB,
    ACC_LH,
    ACC_LW,
    ACC_LBU,
    ACC_LHU,
    ACC_SB,
    ACC_SH,
    ACC_SW
  } access_t;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  funct7;
    logic [31:0] imm;
    logic        is_branch;
    logic        is_jump;
    logic        is_jalr;
  } instr_field_t;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] wdata;
    logic [3:0]  strobe;
    logic        read;
    logic        write;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== hdl/cpu_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_system (
  input  logic              clock,
  input  logic              reset,
  output logic [31:0]       pc,
  input  logic [31:0]       instruction,
  output logic              debug_ebreak,
  output logic              illegal_instruction,
  output logic [31:0][31:0] debug_regs
);
  import cpu_pkg::*;

  mem_req_t    dmem_req;
  logic [31:0] read_data;

  // program comes in from outside, data stays local
  cpu cpu (
    .clock,
    .reset,
    .pc,
    .instruction,
    .dmem_req,
    .read_data,
    .debug_ebreak,
    .illegal_instruction,
    .debug_regs
  );

  data_memory data_memory (
    .clock,
    .reset,
    .req(dmem_req),
    .read_data
  );

endmodule

`default_nettype wire

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory (
  input  logic              clock,
  input  logic              reset,
  input  cpu_pkg::mem_req_t req,
  output logic [31:0]       read_data
);
  import cpu_pkg::*;

  logic [31:0]               mem [DMEM_WORDS];
  logic [DMEM_ADDR_BITS-1:0] word_index;

  // word address, upper bits wrap
  assign word_index = req.address[DMEM_ADDR_BITS+1:2];

  // asynchronous read path for same-cycle loads
  assign read_data = req.read ? mem[word_index] : '0;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (req.write) begin
      for (int b = 0; b < 4; b++) begin
        if (req.strobe[b]) begin
          mem[word_index][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  logic [31:0]           instruction,
  input  logic [31:0]           pc,
  input  logic [31:0]           rs1_data,
  input  logic [31:0]           rs2_data,
  output cpu_pkg::instr_field_t field,
  output cpu_pkg::alu_cmd_t     alu_cmd,
  output cpu_pkg::access_t      access,
  output cpu_pkg::wb_sel_t      wb_sel,
  output logic [31:0]           op1,
  output logic [31:0]           op2,
  output logic                  illegal_instruction
);
  import cpu_pkg::*;

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};
  assign imm_u = {instruction[31:12], 12'b0};
  assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};

  // alt picks sub / sra
  function automatic alu_cmd_t arith_cmd(input logic [2:0] funct3, input logic alt);
    alu_cmd_t cmd;
    case (funct3)
      3'd0:    cmd = alt ? ALU_SUB : ALU_ADD;
      3'd1:    cmd = ALU_SLL;
      3'd2:    cmd = ALU_SLT;
      3'd3:    cmd = ALU_SLTU;
      3'd4:    cmd = ALU_XOR;
      3'd5:    cmd = alt ? ALU_SRA : ALU_SRL;
      3'd6:    cmd = ALU_OR;
      default: cmd = ALU_AND;
    endcase
    return cmd;
  endfunction

  always_comb begin
    field.opcode = opcode_t'(instruction[6:0]);
    field.rd = instruction[11:7];
    field.funct3 = instruction[14:12];
    field.rs1 = instruction[19:15];
    field.rs2 = instruction[24:20];
    field.funct7 = instruction[31:25];
    field.imm = imm_i;
    field.is_branch = 1'b0;
    field.is_jump = 1'b0;
    field.is_jalr = 1'b0;
    alu_cmd = ALU_ADD;
    access = ACC_NONE;
    wb_sel = WB_NONE;
    op1 = rs1_data;
    illegal_instruction = 1'b0;

    case (field.opcode)
      OPC_LUI: begin
        field.imm = imm_u;
        alu_cmd = ALU_PASS_B;
        wb_sel = WB_ALU;
      end
      OPC_AUIPC: begin
        field.imm = imm_u;
        op1 = pc;
        wb_sel = WB_ALU;
      end
      OPC_JAL: begin
        field.imm = imm_j;
        field.is_jump = 1'b1;
        op1 = pc;
        wb_sel = WB_PC4;
      end
      OPC_JALR: begin
        field.is_jalr = 1'b1;
        wb_sel = WB_PC4;
        illegal_instruction = field.funct3 != 3'd0;
      end
      OPC_BRANCH: begin
        field.imm = imm_b;
        field.is_branch = 1'b1;
        op1 = pc;
        case (field.funct3)
          3'd0:    alu_cmd = ALU_EQ;
          3'd1:    alu_cmd = ALU_NE;
          3'd4:    alu_cmd = ALU_LT;
          3'd5:    alu_cmd = ALU_GE;
          3'd6:    alu_cmd = ALU_LTU;
          3'd7:    alu_cmd = ALU_GEU;
          default: illegal_instruction = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        wb_sel = WB_MEM;
        case (field.funct3)
          3'd0:    access = ACC_LB;
          3'd1:    access = ACC_LH;
          3'd2:    access = ACC_LW;
          3'd4:    access = ACC_LBU;
          3'd5:    access = ACC_LHU;
          default: illegal_instruction = 1'b1;
        endcase
      end
      OPC_STORE: begin
        field.imm = imm_s;
        case (field.funct3)
          3'd0:    access = ACC_SB;
          3'd1:    access = ACC_SH;
          3'd2:    access = ACC_SW;
          default: illegal_instruction = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        alu_cmd = arith_cmd(field.funct3, field.funct3 == 3'd5 && field.funct7[5]);
        wb_sel = WB_ALU;
        // shift amounts live in imm[4:0], the upper bits must be clean
        if (field.funct3 == 3'd1) begin
          illegal_instruction = field.funct7 != 7'h00;
        end else if (field.funct3 == 3'd5) begin
          illegal_instruction = field.funct7 != 7'h00 && field.funct7 != 7'h20;
        end
      end
      OPC_OP: begin
        alu_cmd = arith_cmd(field.funct3, field.funct7[5]);
        wb_sel = WB_ALU;
        illegal_instruction = !(field.funct7 == 7'h00 ||
                                (field.funct7 == 7'h20 &&
                                 (field.funct3 == 3'd0 || field.funct3 == 3'd5)));
      end
      OPC_SYSTEM: illegal_instruction = instruction != EBREAK_WORD;
      default:    illegal_instruction = 1'b1;
    endcase

    // illegal words fall through as a plain pc+4
    if (illegal_instruction) begin
      wb_sel = WB_NONE;
      access = ACC_NONE;
      field.is_branch = 1'b0;
      field.is_jump = 1'b0;
      field.is_jalr = 1'b0;
    end

    op2 = (field.opcode == OPC_OP) ? rs2_data : field.imm;
  end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  logic [31:0]       op1,
  input  logic [31:0]       op2,
  input  logic [31:0]       rs1_data,
  input  logic [31:0]       rs2_data,
  input  cpu_pkg::alu_cmd_t alu_cmd,
  output logic [31:0]       alu_out,
  output logic              branch_taken
);
  import cpu_pkg::*;

  logic [31:0] sum;

  assign sum = op1 + op2;

  always_comb begin
    alu_out = sum;
    branch_taken = 1'b0;
    case (alu_cmd)
      ALU_SUB:    alu_out = op1 - op2;
      ALU_SLL:    alu_out = op1 << op2[4:0];
      ALU_SLT:    alu_out = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU:   alu_out = {31'b0, op1 < op2};
      ALU_XOR:    alu_out = op1 ^ op2;
      ALU_SRL:    alu_out = op1 >> op2[4:0];
      ALU_SRA:    alu_out = $signed(op1) >>> op2[4:0];
      ALU_OR:     alu_out = op1 | op2;
      ALU_AND:    alu_out = op1 & op2;
      ALU_PASS_B: alu_out = op2;
      // branches keep the sum as target, compare the registers
      ALU_EQ:     branch_taken = rs1_data == rs2_data;
      ALU_NE:     branch_taken = rs1_data != rs2_data;
      ALU_LT:     branch_taken = $signed(rs1_data) < $signed(rs2_data);
      ALU_GE:     branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      ALU_LTU:    branch_taken = rs1_data < rs2_data;
      ALU_GEU:    branch_taken = rs1_data >= rs2_data;
      default:    alu_out = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/memory_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_access (
  input  cpu_pkg::access_t access,
  input  logic [31:0]      address,
  input  logic [31:0]      store_value,
  input  logic [31:0]      read_data,
  output logic [3:0]       strobe,
  output logic [31:0]      wdata,
  output logic             read,
  output logic             write,
  output logic [31:0]      load_value
);
  import cpu_pkg::*;

  logic [31:0] lane_data;

  // selected byte or halfword moved down to bit 0
  assign lane_data = read_data >> {address[1:0], 3'b000};

  assign read = access inside {ACC_LB, ACC_LH, ACC_LW, ACC_LBU, ACC_LHU};
  assign write = access inside {ACC_SB, ACC_SH, ACC_SW};

  always_comb begin
    strobe = 4'b0000;
    wdata = store_value;
    case (access)
      ACC_SB: begin
        strobe = 4'b0001 << address[1:0];
        wdata = {4{store_value[7:0]}};
      end
      ACC_SH: begin
        strobe = address[1] ? 4'b1100 : 4'b0011;
        wdata = {2{store_value[15:0]}};
      end
      ACC_SW:  strobe = 4'b1111;
      default: strobe = 4'b0000;
    endcase
  end

  always_comb begin
    case (access)
      ACC_LB:  load_value = {{24{lane_data[7]}}, lane_data[7:0]};
      ACC_LBU: load_value = {24'b0, lane_data[7:0]};
      ACC_LH:  load_value = {{16{lane_data[15]}}, lane_data[15:0]};
      ACC_LHU: load_value = {16'b0, lane_data[15:0]};
      default: load_value = read_data;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/write_back.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_back (
  input  logic [31:0]           pc,
  input  cpu_pkg::instr_field_t field,
  input  cpu_pkg::wb_sel_t      wb_sel,
  input  logic [31:0]           alu_out,
  input  logic                  branch_taken,
  input  logic [31:0]           load_value,
  output logic [31:0]           reg_next,
  output logic                  wb_en,
  output logic [31:0]           pc_next
);
  import cpu_pkg::*;

  logic [31:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  // register write source
  always_comb begin
    case (wb_sel)
      WB_ALU:  reg_next = alu_out;
      WB_MEM:  reg_next = load_value;
      WB_PC4:  reg_next = pc_plus4;
      default: reg_next = '0;
    endcase
  end

  // x0 is never written
  assign wb_en = (wb_sel != WB_NONE) && (field.rd != 5'd0);

  always_comb begin
    if (field.is_jalr) begin
      pc_next = {alu_out[31:1], 1'b0};
    end else if (field.is_jump || (field.is_branch && branch_taken)) begin
      pc_next = alu_out;
    end else begin
      pc_next = pc_plus4;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/cpu_pkg.sv
hdl/decoder.sv
hdl/execute.sv
hdl/memory_access.sv
hdl/write_back.sv
hdl/cpu.sv
hdl/data_memory.sv
hdl/cpu_system.sv
bench/cpu_checker.sv
bench/cpu_tb.sv
